//--- sim.f
src/frame_pkg.sv
src/ps2_scan_decode.sv
src/key_state.sv
src/board_reset.sv
src/game_ctrl_out.sv
src/jtframe_inputs.sv
test/jtframe_inputs_tb.sv

//--- src/board_reset.sv
`timescale 1ns/1ns

module board_reset #(
    parameter int RST_CYCLES = 32
)(
    input        clk_sys,
    input        rst,
    input        downloading,
    input        dip_flip,
    input        rst_req,
    output logic game_rst
);

    localparam int CW = $clog2(RST_CYCLES + 1);

    logic          dip_q;       // dip_flip one cycle back
    logic          trigger;
    logic [CW-1:0] cnt_q;
    logic [CW-1:0] cnt_d;

    assign trigger = rst || downloading || (dip_flip != dip_q) || rst_req;

    // Reload on every trigger cycle, else count down to zero
    always_comb begin
        if (trigger) begin
            cnt_d = CW'(RST_CYCLES);
        end else if (cnt_q != '0) begin
            cnt_d = cnt_q - 1'b1;
        end else begin
            cnt_d = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        dip_q <= dip_flip;
        cnt_q <= cnt_d;         // rst itself loads the count
    end

    // Registered copy of the nonzero count
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_rst <= 1'b1;
        end else begin
            game_rst <= (cnt_d != '0);
        end
    end

endmodule

//--- src/frame_pkg.sv
package frame_pkg;

    typedef logic [7:0] scan_code_t;       // One PS/2 byte
    typedef logic [9:0] joy_t;             // Game joystick word, active high

    // Keyboard event, one per non-prefix scan byte
    typedef struct packed {
        logic       valid;
        logic       make;                  // Press, 0 on release
        logic       ext;                   // Came after E0
        scan_code_t code;
    } key_evt_t;

    typedef struct packed {
        joy_t       joy1;
        joy_t       joy2;
        logic [1:0] coin;
        logic [1:0] start;
        logic       pause;
        logic       service;
    } ctrl_t;

    // Bit positions inside joy_t
    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;
    localparam int JOY_B1    = 4;
    localparam int JOY_B2    = 5;
    localparam int JOY_B3    = 6;

    localparam scan_code_t SC_BREAK = 8'hF0;
    localparam scan_code_t SC_EXT   = 8'hE0;

    // Player 1 arrows, extended set
    localparam scan_code_t SC_P1_UP    = 8'h75;
    localparam scan_code_t SC_P1_DOWN  = 8'h72;
    localparam scan_code_t SC_P1_LEFT  = 8'h6B;
    localparam scan_code_t SC_P1_RIGHT = 8'h74;
    localparam scan_code_t SC_P1_B1    = 8'h14;   // Left Ctrl
    localparam scan_code_t SC_P1_B2    = 8'h11;   // Left Alt
    localparam scan_code_t SC_P1_B3    = 8'h29;   // Space

    localparam scan_code_t SC_P2_UP    = 8'h2D;   // R
    localparam scan_code_t SC_P2_DOWN  = 8'h2B;   // F
    localparam scan_code_t SC_P2_LEFT  = 8'h23;   // D
    localparam scan_code_t SC_P2_RIGHT = 8'h34;   // G
    localparam scan_code_t SC_P2_B1    = 8'h1C;   // A
    localparam scan_code_t SC_P2_B2    = 8'h1B;   // S
    localparam scan_code_t SC_P2_B3    = 8'h15;   // Q

    localparam scan_code_t SC_START1   = 8'h16;   // 1
    localparam scan_code_t SC_START2   = 8'h1E;   // 2
    localparam scan_code_t SC_COIN1    = 8'h2E;   // 5
    localparam scan_code_t SC_COIN2    = 8'h36;   // 6
    localparam scan_code_t SC_SERVICE  = 8'h06;   // F2
    localparam scan_code_t SC_PAUSE    = 8'h4D;   // P

endpackage

//--- src/game_ctrl_out.sv
`timescale 1ns/1ns

module game_ctrl_out #(
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
)(
    input                    clk_sys,
    input                    rst,
    input                    game_rst,
    input  frame_pkg::ctrl_t ctrl,
    output frame_pkg::joy_t  game_joystick1,
    output frame_pkg::joy_t  game_joystick2,
    output logic [1:0]       game_coin,
    output logic [1:0]       game_start,
    output logic             game_pause,
    output logic             game_service
);

    import frame_pkg::*;

    ctrl_t masked;
    ctrl_t out_q;

    always_comb begin
        masked = ctrl;
        if (!THREE_BUTTONS) begin
            masked.joy1[JOY_B3] = 1'b0;     // Third button unused by the game
            masked.joy2[JOY_B3] = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            out_q <= GAME_INPUTS_ACTIVE_HIGH ? '0 : '1;   // Released level
        end else begin
            out_q <= GAME_INPUTS_ACTIVE_HIGH ? masked : ~masked;
        end
    end

    assign game_joystick1 = out_q.joy1;
    assign game_joystick2 = out_q.joy2;
    assign game_coin      = out_q.coin;
    assign game_start     = out_q.start;
    assign game_pause     = out_q.pause;
    assign game_service   = out_q.service;

endmodule

//--- src/jtframe_inputs.sv
`timescale 1ns/1ns

module jtframe_inputs #(
    parameter int RST_CYCLES              = 32,
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
)(
    input                         clk_sys,
    input                         rst,
    // Keyboard byte stream
    input  frame_pkg::scan_code_t scan_data,
    input                         scan_valid,
    // Controllers, active high
    input  frame_pkg::joy_t       board_joystick1,
    input  frame_pkg::joy_t       board_joystick2,
    // Reset sources
    input                         downloading,
    input                         dip_flip,
    input                         rst_req,
    output logic                  game_rst,
    // To the game
    output frame_pkg::joy_t       game_joystick1,
    output frame_pkg::joy_t       game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_pause,
    output logic                  game_service
);

    import frame_pkg::*;

    key_evt_t evt;
    ctrl_t    ctrl;

    ps2_scan_decode u_decode(
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .scan_data      ( scan_data       ),
        .scan_valid     ( scan_valid      ),
        .evt            ( evt             )
    );

    key_state u_keys(
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .game_rst       ( game_rst        ),
        .evt            ( evt             ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .ctrl           ( ctrl            )
    );

    board_reset #(.RST_CYCLES(RST_CYCLES)) u_reset(
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .downloading    ( downloading     ),
        .dip_flip       ( dip_flip        ),
        .rst_req        ( rst_req         ),
        .game_rst       ( game_rst        )
    );

    game_ctrl_out #(
        .THREE_BUTTONS          ( THREE_BUTTONS           ),
        .GAME_INPUTS_ACTIVE_HIGH( GAME_INPUTS_ACTIVE_HIGH )
    ) u_out(
        .clk_sys        ( clk_sys         ),
        .rst            ( rst             ),
        .game_rst       ( game_rst        ),
        .ctrl           ( ctrl            ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      ),
        .game_service   ( game_service    )
    );

endmodule

//--- src/key_state.sv
`timescale 1ns/1ns

module key_state(
    input                     clk_sys,
    input                     rst,
    input                     game_rst,
    input  frame_pkg::key_evt_t evt,
    input  frame_pkg::joy_t   board_joystick1,
    input  frame_pkg::joy_t   board_joystick2,
    output frame_pkg::ctrl_t  ctrl
);

    import frame_pkg::*;

    ctrl_t kb_q;        // Keyboard side only
    ctrl_t kb_d;

    always_comb begin
        kb_d = kb_q;
        if (evt.valid) begin
            if (evt.ext) begin
                // Arrows only exist in the extended set
                case (evt.code)
                    SC_P1_UP:    kb_d.joy1[JOY_UP]    = evt.make;
                    SC_P1_DOWN:  kb_d.joy1[JOY_DOWN]  = evt.make;
                    SC_P1_LEFT:  kb_d.joy1[JOY_LEFT]  = evt.make;
                    SC_P1_RIGHT: kb_d.joy1[JOY_RIGHT] = evt.make;
                    default: ;
                endcase
            end else begin
                case (evt.code)
                    SC_P1_B1:    kb_d.joy1[JOY_B1]    = evt.make;
                    SC_P1_B2:    kb_d.joy1[JOY_B2]    = evt.make;
                    SC_P1_B3:    kb_d.joy1[JOY_B3]    = evt.make;
                    SC_P2_UP:    kb_d.joy2[JOY_UP]    = evt.make;
                    SC_P2_DOWN:  kb_d.joy2[JOY_DOWN]  = evt.make;
                    SC_P2_LEFT:  kb_d.joy2[JOY_LEFT]  = evt.make;
                    SC_P2_RIGHT: kb_d.joy2[JOY_RIGHT] = evt.make;
                    SC_P2_B1:    kb_d.joy2[JOY_B1]    = evt.make;
                    SC_P2_B2:    kb_d.joy2[JOY_B2]    = evt.make;
                    SC_P2_B3:    kb_d.joy2[JOY_B3]    = evt.make;
                    SC_START1:   kb_d.start[0]        = evt.make;
                    SC_START2:   kb_d.start[1]        = evt.make;
                    SC_COIN1:    kb_d.coin[0]         = evt.make;
                    SC_COIN2:    kb_d.coin[1]         = evt.make;
                    SC_SERVICE:  kb_d.service         = evt.make;
                    SC_PAUSE: begin
                        if (evt.make) begin
                            kb_d.pause = !kb_q.pause;   // Break ignored
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            kb_q <= '0;
            ctrl <= '0;
        end else begin
            kb_q <= kb_d;
            ctrl <= kb_d;
            // Board sticks join in the same register stage
            ctrl.joy1 <= kb_d.joy1 | board_joystick1;
            ctrl.joy2 <= kb_d.joy2 | board_joystick2;
        end
    end

endmodule

//--- src/ps2_scan_decode.sv
`timescale 1ns/1ns

module ps2_scan_decode(
    input                        clk_sys,
    input                        rst,
    input  frame_pkg::scan_code_t scan_data,
    input                        scan_valid,
    output frame_pkg::key_evt_t  evt
);

    import frame_pkg::*;

    logic brk_pend;     // F0 seen
    logic ext_pend;     // E0 seen
    logic is_prefix;

    assign is_prefix = (scan_data == SC_BREAK) || (scan_data == SC_EXT);

    // Prefix flags and event strobe
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            brk_pend  <= 1'b0;
            ext_pend  <= 1'b0;
            evt.valid <= 1'b0;
        end else begin
            evt.valid <= scan_valid && !is_prefix;
            if (scan_valid) begin
                if (scan_data == SC_BREAK) begin
                    brk_pend <= 1'b1;
                end else if (scan_data == SC_EXT) begin
                    ext_pend <= 1'b1;
                end else begin
                    // Key byte closes the sequence
                    brk_pend <= 1'b0;
                    ext_pend <= 1'b0;
                end
            end
        end
    end

    // Event payload, only meaningful with valid
    always_ff @(posedge clk_sys) begin
        if (scan_valid && !is_prefix) begin
            evt.make <= !brk_pend;
            evt.ext  <= ext_pend;
            evt.code <= scan_data;
        end
    end

endmodule

//--- test/input_vectors.txt
// test scan kind(1 byte, 3 F0+byte, 5 E0+byte, 7 E0 F0+byte) joy1 joy2 dl dip rreq wait
// then expected, active high: joy1 joy2 coin start pause service game_rst (all hex)
1 00 0 000 000 0 0 0 1F  000 000 0 0 0 0 1
1 00 0 000 000 0 0 0 01  000 000 0 0 0 0 0
2 75 5 000 000 0 0 0 04  008 000 0 0 0 0 0
2 75 7 000 000 0 0 0 04  000 000 0 0 0 0 0
2 14 1 000 000 0 0 0 04  010 000 0 0 0 0 0
2 75 1 000 000 0 0 0 04  010 000 0 0 0 0 0
2 29 1 000 000 0 0 0 04  010 000 0 0 0 0 0
3 2D 1 000 000 0 0 0 04  010 008 0 0 0 0 0
3 2D 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 1C 1 000 000 0 0 0 04  010 010 0 0 0 0 0
3 1C 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 16 1 000 000 0 0 0 04  010 000 0 1 0 0 0
3 16 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 1E 1 000 000 0 0 0 04  010 000 0 2 0 0 0
3 1E 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 2E 1 000 000 0 0 0 04  010 000 1 0 0 0 0
3 2E 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 36 1 000 000 0 0 0 04  010 000 2 0 0 0 0
3 36 3 000 000 0 0 0 04  010 000 0 0 0 0 0
3 06 1 000 000 0 0 0 04  010 000 0 0 0 1 0
3 06 3 000 000 0 0 0 04  010 000 0 0 0 0 0
4 4D 1 000 000 0 0 0 04  010 000 0 0 1 0 0
4 4D 3 000 000 0 0 0 04  010 000 0 0 1 0 0
4 4D 1 000 000 0 0 0 04  010 000 0 0 0 0 0
5 00 0 284 148 0 0 0 03  294 108 0 0 0 0 0
5 00 0 000 000 0 0 0 03  010 000 0 0 0 0 0
6 4D 1 000 000 0 0 0 04  010 000 0 0 1 0 0
6 75 5 000 000 0 0 0 04  018 000 0 0 1 0 0
6 00 0 000 000 0 1 0 0A  000 000 0 0 0 0 1
6 00 0 000 000 0 1 1 0A  000 000 0 0 0 0 1
6 00 0 000 000 1 1 0 20  000 000 0 0 0 0 1
6 00 0 000 000 0 1 0 01  000 000 0 0 0 0 0
6 00 0 000 000 0 1 0 03  000 000 0 0 0 0 0

//--- test/jtframe_inputs_tb.sv
`timescale 1ns/1ns

module jtframe_inputs_tb;

    import frame_pkg::*;

    localparam int NF        = 16;      // Fields per vector line
    localparam int MAX_STEPS = 64;
    localparam int STRETCH   = 32;      // Game reset length in cycles

    logic       clk_sys = 1'b0;
    logic       rst;
    scan_code_t scan_data;
    logic       scan_valid;
    joy_t       board_joystick1;
    joy_t       board_joystick2;
    logic       downloading;
    logic       dip_flip;
    logic       rst_req;
    logic       game_rst;
    joy_t       game_joystick1;
    joy_t       game_joystick2;
    logic [1:0] game_coin;
    logic [1:0] game_start;
    logic       game_pause;
    logic       game_service;

    logic [11:0] vec [0:NF*MAX_STEPS-1];
    int num_steps;
    int cycle_count = 0;
    int cycle_limit = 0;
    int errors      = 0;
    int checks      = 0;
    int tests_run   = 0;
    int test_steps  = 0;
    int test_errors = 0;

    jtframe_inputs jtframe_inputs_i(.*);   // Default parameters, active low outputs

    always #10 clk_sys = ~clk_sys;

    always @(posedge clk_sys) cycle_count <= cycle_count + 1;

    task automatic report_mismatch(input string name, input logic [9:0] got,
                                   input logic [9:0] exp);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic send_byte(input scan_code_t code);
        scan_data  = code;
        scan_valid = 1'b1;
        @(posedge clk_sys);
        #2;
        scan_valid = 1'b0;
    endtask

    // Prefixes first, then the key byte together with the level inputs
    task automatic run_step(input int base);
        logic [3:0] kind;
        int         i;
        kind = vec[base+2][3:0];
        if (kind[2]) send_byte(SC_EXT);
        if (kind[1]) send_byte(SC_BREAK);
        scan_data       = vec[base+1][7:0];
        scan_valid      = kind[0];
        board_joystick1 = vec[base+3][9:0];
        board_joystick2 = vec[base+4][9:0];
        downloading     = vec[base+5][0];
        dip_flip        = vec[base+6][0];
        rst_req         = vec[base+7][0];
        for (i = 0; i < vec[base+8]; i++) begin
            @(posedge clk_sys);
            #2;
            scan_valid  = 1'b0;         // Pulses last one cycle
            downloading = 1'b0;
            rst_req     = 1'b0;
        end
    endtask

    task automatic check_outputs(input int base);
        joy_t       exp_j1;
        joy_t       exp_j2;
        logic [1:0] exp_coin;
        logic [1:0] exp_start;
        logic       exp_pause;
        logic       exp_service;
        exp_j1      = ~vec[base+9][9:0];      // File holds active high values
        exp_j2      = ~vec[base+10][9:0];
        exp_coin    = ~vec[base+11][1:0];
        exp_start   = ~vec[base+12][1:0];
        exp_pause   = ~vec[base+13][0];
        exp_service = ~vec[base+14][0];
        checks += 7;
        assert (game_joystick1 === exp_j1)
            else report_mismatch("game_joystick1", game_joystick1, exp_j1);
        assert (game_joystick2 === exp_j2)
            else report_mismatch("game_joystick2", game_joystick2, exp_j2);
        assert (game_coin === exp_coin)
            else report_mismatch("game_coin", game_coin, exp_coin);
        assert (game_start === exp_start)
            else report_mismatch("game_start", game_start, exp_start);
        assert (game_pause === exp_pause)
            else report_mismatch("game_pause", game_pause, exp_pause);
        assert (game_service === exp_service)
            else report_mismatch("game_service", game_service, exp_service);
        assert (game_rst === vec[base+15][0])
            else report_mismatch("game_rst", game_rst, vec[base+15][0]);
    endtask

    // Lone rst_req pulse while game_rst is idle, then time the stretch
    task automatic check_rst_req_stretch();
        rst_req = 1'b1;
        @(posedge clk_sys);
        #2;
        rst_req = 1'b0;
        checks += 3;
        assert (game_rst === 1'b1)
            else report_mismatch("game_rst", game_rst, 1'b1);
        repeat (STRETCH - 1) @(posedge clk_sys);
        #2;
        assert (game_rst === 1'b1)
            else report_mismatch("game_rst", game_rst, 1'b1);
        @(posedge clk_sys);
        #2;
        assert (game_rst === 1'b0)
            else report_mismatch("game_rst", game_rst, 1'b0);
        test_steps++;
    endtask

    task automatic close_test(input int id);
        $display("Test %0d: %0d steps, %0d errors, %s", id, test_steps, test_errors,
                 (test_errors == 0) ? "ok" : "bad");
        tests_run++;
        test_steps  = 0;
        test_errors = 0;
    endtask

    initial begin
        int s;
        int base;
        int cur_test;
        rst             = 1'b1;
        scan_data       = '0;
        scan_valid      = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        downloading     = 1'b0;
        dip_flip        = 1'b0;
        rst_req         = 1'b0;
        $readmemh("test/input_vectors.txt", vec);
        num_steps = 0;
        while (num_steps < MAX_STEPS && !$isunknown(vec[num_steps*NF])) begin
            num_steps++;
        end
        // Reset, stretch, waits, up to two prefix cycles per step, rst_req pulse, margin
        cycle_limit = 16 + STRETCH + (STRETCH + 1) + 200;
        for (s = 0; s < num_steps; s++) begin
            cycle_limit += vec[s*NF+8] + 3;
        end
        assert (num_steps > 0) else begin
            $display("No stimulus lines were read from test/input_vectors.txt");
            errors++;
        end
        repeat (16) @(posedge clk_sys);
        #2;
        checks++;
        assert (game_rst === 1'b1) else report_mismatch("game_rst", game_rst, 1'b1);
        rst      = 1'b0;
        cur_test = -1;
        for (s = 0; s < num_steps; s++) begin
            base = s * NF;
            if (vec[base] != cur_test) begin
                if (cur_test >= 0) close_test(cur_test);
                cur_test = vec[base];
            end
            run_step(base);
            check_outputs(base);
            test_steps++;
        end
        if (cur_test >= 0) close_test(cur_test);
        check_rst_req_stretch();
        close_test(cur_test + 1);
        $display("Done: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycle_limit != 0 && cycle_count >= cycle_limit);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

endmodule
